// File: compile.f
design/join_pkg.sv
design/port_fifo.sv
design/frame_joiner.sv
design/skid_buffer.sv
design/frame_join_top.sv
test/tb_clock_gen.sv
test/frame_join_tb.sv

// File: Bender.yml
package:
  name: frame_join

sources:
  - files:
      - design/join_pkg.sv
      - design/port_fifo.sv
      - design/frame_joiner.sv
      - design/skid_buffer.sv
      - design/frame_join_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/frame_join_tb.sv

// File: test/frame_join_tb.sv
// frame joiner testbench
`timescale 1ns/1ps

module frame_join_tb;

    localparam int NPORTS    = 3;
    localparam int TAG_W     = 16;
    localparam int DEPTH     = 4;
    localparam int MAX_LEN   = 6;
    localparam int NDIRECT   = 6;
    localparam int NROUNDS   = NDIRECT + 30;
    localparam int R_EARLY   = 4;
    localparam int R_HOLD    = 5;
    localparam int CLK_NS    = 20;
    localparam int TAG_BYTES = (TAG_W + 8 * join_pkg::BEAT_BYTES - 1) / (8 * join_pkg::BEAT_BYTES);

    typedef join_pkg::join_beat_t beat_q_t [$];

    logic                 clk;
    logic                 rst;
    join_pkg::join_beat_t in_beat [NPORTS];
    logic [NPORTS-1:0]    in_valid;
    logic [NPORTS-1:0]    in_ready;
    join_pkg::join_beat_t out_beat;
    logic                 out_valid;
    logic                 out_ready;
    logic [TAG_W-1:0]     tag;
    logic                 busy;

    // all rounds are generated up front
    join_pkg::join_beat_t tbl_beat [NROUNDS][NPORTS][MAX_LEN];
    int                   tbl_gap [NROUNDS][NPORTS][MAX_LEN];
    int                   tbl_len [NROUNDS][NPORTS];
    logic [TAG_W-1:0]     tbl_tag [NROUNDS];

    // round being driven
    join_pkg::join_beat_t cur_frames [NPORTS][MAX_LEN];
    int                   cur_gaps [NPORTS][MAX_LEN];
    int                   cur_lens [NPORTS];

    beat_q_t              exp_q;
    join_pkg::join_beat_t exp_beat;
    logic [31:0]          stim_lfsr = 32'h31bb;
    logic [31:0]          ready_lfsr = 32'h31bb;
    logic                 ready_random = 1'b0;
    int                   low_left = 0;
    int                   mismatch_count = 0;
    int                   other_count = 0;
    int                   rx_count = 0;
    longint               limit_ns = 0;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_NS),
        .RESET_CYCLES (2)
    ) u_clk (
        .clk (clk),
        .rst (rst)
    );

    frame_join_top #(
        .PORT_COUNT (NPORTS),
        .TAG_WIDTH  (TAG_W),
        .FIFO_DEPTH (DEPTH)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .tag       (tag),
        .busy      (busy)
    );

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            val = {val[30:0], stim_lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] ready_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            ready_lfsr = lfsr_next(ready_lfsr);
            val = {val[30:0], ready_lfsr[0]};
        end
        return val;
    endfunction

    // expected output of one round: tag bytes, then every port's frame in order
    function automatic beat_q_t join_model(input join_pkg::join_beat_t frames [NPORTS][MAX_LEN],
                                           input int lens [NPORTS],
                                           input logic [TAG_W-1:0] tag_val);
        beat_q_t              q;
        join_pkg::join_beat_t b;
        logic                 user_or;
        int                   t;
        int                   p;
        int                   k;
        user_or = 1'b0;
        for (t = 0; t < TAG_BYTES; t++) begin
            b.data = 8'(tag_val >> (8 * t));
            b.last = 1'b0;
            b.user = 1'b0;
            q.push_back(b);
        end
        for (p = 0; p < NPORTS; p++) begin
            for (k = 0; k < lens[p]; k++) begin
                b.data = frames[p][k].data;
                b.last = 1'b0;
                b.user = 1'b0;
                if (k == lens[p] - 1) begin
                    user_or = user_or | frames[p][k].user;
                    if (p == NPORTS - 1) begin
                        b.last = 1'b1;
                        b.user = user_or;
                    end
                end
                q.push_back(b);
            end
        end
        return q;
    endfunction

    task automatic check_beat(input join_pkg::join_beat_t got, input join_pkg::join_beat_t exp,
                              input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %02h/%0b/%0b expected %02h/%0b/%0b (data/last/user)",
                     $time, what, got.data, got.last, got.user, exp.data, exp.last, exp.user);
        end
    endtask

    task automatic check_busy(input logic exp, input string what);
        if (busy !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: busy %0b expected %0b, %s", $time, busy, exp, what);
        end
    endtask

    task automatic build_tables;
        int r;
        int p;
        int k;
        int len;
        int total;
        total = 0;
        for (r = 0; r < NROUNDS; r++) begin
            tbl_tag[r] = TAG_W'(stim_bits(TAG_W));
            for (p = 0; p < NPORTS; p++) begin
                // short port 2 frame fits the FIFO while the other ports wait
                if ((r == R_EARLY || r == R_HOLD) && p == NPORTS - 1) begin
                    len = 3;
                end else begin
                    len = int'(stim_bits(3) % MAX_LEN) + 1;
                end
                tbl_len[r][p] = len;
                total += len;
                for (k = 0; k < MAX_LEN; k++) begin
                    tbl_beat[r][p][k].data = 8'(stim_bits(8));
                    tbl_beat[r][p][k].user = 1'(stim_bits(1));
                    tbl_beat[r][p][k].last = (k == len - 1);
                    tbl_gap[r][p][k] = (r < NDIRECT) ? 0 : int'(stim_bits(2));
                end
                // directed rounds: user ends only port r-1 in rounds 1 to 3
                if (r < NDIRECT) begin
                    tbl_beat[r][p][len-1].user = (r >= 1 && r <= NPORTS && p == r - 1);
                end
            end
        end
        limit_ns = longint'(40) * total * CLK_NS + 2000;
    endtask

    task automatic load_round(input int r);
        beat_q_t q;
        int      p;
        int      k;
        for (p = 0; p < NPORTS; p++) begin
            cur_lens[p] = tbl_len[r][p];
            for (k = 0; k < MAX_LEN; k++) begin
                cur_frames[p][k] = tbl_beat[r][p][k];
                cur_gaps[p][k] = tbl_gap[r][p][k];
            end
        end
        tag = tbl_tag[r];
        q = join_model(cur_frames, cur_lens, tbl_tag[r]);
        for (k = 0; k < q.size(); k++) begin
            exp_q.push_back(q[k]);
        end
    endtask

    // entered on a falling edge, returns on one
    task automatic drive_frame(input int p);
        int k;
        for (k = 0; k < cur_lens[p]; k++) begin
            repeat (cur_gaps[p][k]) @(negedge clk);
            in_beat[p] = cur_frames[p][k];
            in_valid[p] = 1'b1;
            while (!in_ready[p]) @(negedge clk);
            @(negedge clk);
            in_valid[p] = 1'b0;
        end
    endtask

    task automatic wait_round_end(input string what);
        while (exp_q.size() != 0) @(negedge clk);
        check_busy(1'b0, what);
    endtask

    task automatic run_round(input int r);
        load_round(r);
        fork
            drive_frame(0);
            drive_frame(1);
            drive_frame(2);
        join
        wait_round_end($sformatf("after round %0d", r));
    endtask

    // out_ready pattern with random low stretches
    initial begin
        out_ready = 1'b0;
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (!ready_random) begin
                out_ready = 1'b1;
            end else if (low_left > 0) begin
                out_ready = 1'b0;
                low_left--;
            end else if (ready_bits(3) == 0) begin
                out_ready = 1'b0;
                low_left = int'(ready_bits(2));
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // accepted output beats against the model queue
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                other_count++;
                $display("unexpected output beat at %0t, data %02h", $time, out_beat.data);
            end else begin
                exp_beat = exp_q.pop_front();
                check_beat(out_beat, exp_beat, $sformatf("output beat %0d", rx_count));
            end
            rx_count++;
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        other_count++;
        $display("timeout: run did not finish within %0d ns", limit_ns);
        if (exp_q.size() != 0) begin
            other_count++;
            $display("%0d expected output beats never arrived", exp_q.size());
        end
        $display("checked %0d beats, %0d mismatches, %0d other errors",
                 rx_count, mismatch_count, other_count);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int r;
        int p;
        int base;
        in_valid = '0;
        for (p = 0; p < NPORTS; p++) begin
            in_beat[p] = '0;
        end
        tag = '0;
        build_tables();
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        @(negedge clk);
        check_busy(1'b0, "after reset");

        // plain rounds, then each port alone ending with user set
        for (r = 0; r < R_EARLY; r++) begin
            run_round(r);
        end

        // port 2 complete before port 0 starts
        base = rx_count;
        load_round(R_EARLY);
        drive_frame(2);
        repeat (4) @(negedge clk);
        if (rx_count != base) begin
            other_count++;
            $display("output started at %0t before port 0 had data", $time);
        end
        fork
            drive_frame(0);
            drive_frame(1);
        join
        wait_round_end("port 2 first");

        // round stalls on port 1
        base = rx_count;
        load_round(R_HOLD);
        fork
            drive_frame(0);
            drive_frame(2);
        join
        while (rx_count < base + TAG_BYTES + cur_lens[0]) @(negedge clk);
        repeat (4) @(negedge clk);
        if (rx_count != base + TAG_BYTES + cur_lens[0]) begin
            other_count++;
            $display("output went past port 0 at %0t while port 1 was held", $time);
        end
        check_busy(1'b1, "round stalled on port 1");
        drive_frame(1);
        wait_round_end("port 1 held");

        // random gaps and back-pressure
        @(posedge clk);
        ready_random = 1'b1;
        @(negedge clk);
        for (r = NDIRECT; r < NROUNDS; r++) begin
            run_round(r);
        end
        // quiet window that catches extra output beats
        repeat (10) @(negedge clk);

        $display("checked %0d beats, %0d mismatches, %0d other errors",
                 rx_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: test/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset spans RESET_CYCLES rising edges and drops on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: design/frame_join_top.sv
// frame joiner top level
`timescale 1ns/1ps

module frame_join_top #(
    parameter int PORT_COUNT = 4,
    parameter int TAG_WIDTH  = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,

    input  join_pkg::join_beat_t  in_beat [PORT_COUNT],
    input  logic [PORT_COUNT-1:0] in_valid,
    output logic [PORT_COUNT-1:0] in_ready,

    output join_pkg::join_beat_t  out_beat,
    output logic                  out_valid,
    input  logic                  out_ready,

    input  logic [TAG_WIDTH-1:0]  tag,
    output logic                  busy
);

    join_pkg::join_beat_t  fifo_beat [PORT_COUNT];
    logic [PORT_COUNT-1:0] fifo_valid;
    logic [PORT_COUNT-1:0] fifo_ready;

    join_pkg::join_beat_t join_beat;
    logic                 join_valid;
    logic                 join_ready;

    // one input FIFO per port
    for (genvar i = 0; i < PORT_COUNT; i++) begin : g_port
        port_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .rst      (rst),
            .wr_beat  (in_beat[i]),
            .wr_valid (in_valid[i]),
            .wr_ready (in_ready[i]),
            .rd_beat  (fifo_beat[i]),
            .rd_valid (fifo_valid[i]),
            .rd_ready (fifo_ready[i])
        );
    end

    frame_joiner #(
        .PORT_COUNT(PORT_COUNT),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_joiner (
        .clk       (clk),
        .rst       (rst),
        .src_beat  (fifo_beat),
        .src_valid (fifo_valid),
        .src_ready (fifo_ready),
        .dst_beat  (join_beat),
        .dst_valid (join_valid),
        .dst_ready (join_ready),
        .tag       (tag),
        .busy      (busy)
    );

    skid_buffer u_skid (
        .clk        (clk),
        .rst        (rst),
        .up_beat    (join_beat),
        .up_valid   (join_valid),
        .up_ready   (join_ready),
        .down_beat  (out_beat),
        .down_valid (out_valid),
        .down_ready (out_ready)
    );

endmodule

// File: design/skid_buffer.sv
// output skid buffer
`timescale 1ns/1ps

module skid_buffer (
    input  logic                 clk,
    input  logic                 rst,

    input  join_pkg::join_beat_t up_beat,
    input  logic                 up_valid,
    output logic                 up_ready,

    output join_pkg::join_beat_t down_beat,
    output logic                 down_valid,
    input  logic                 down_ready
);

    join_pkg::join_beat_t temp_beat;
    logic                 temp_valid;

    logic up_fire;
    logic ready_early;
    logic store_up_to_out;
    logic store_up_to_temp;
    logic store_temp_to_out;

    assign up_fire = up_valid && up_ready;

    // stay ready unless the temp entry could fill on this edge
    assign ready_early = down_ready || (!temp_valid && (!down_valid || !up_fire));

    assign store_up_to_out   = up_ready && (down_ready || !down_valid);
    assign store_up_to_temp  = up_ready && !down_ready && down_valid;
    assign store_temp_to_out = !up_ready && down_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            down_valid <= 1'b0;
            temp_valid <= 1'b0;
            up_ready   <= 1'b0;
        end else begin
            up_ready <= ready_early;
            if (store_up_to_out) begin
                down_valid <= up_valid;
            end else if (store_up_to_temp) begin
                temp_valid <= up_valid;
            end else if (store_temp_to_out) begin
                down_valid <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (store_up_to_out) begin
            down_beat <= up_beat;
        end else if (store_temp_to_out) begin
            down_beat <= temp_beat;
        end
        if (store_up_to_temp) begin
            temp_beat <= up_beat;
        end
    end

endmodule

// File: design/frame_joiner.sv
// frame joiner FSM
`timescale 1ns/1ps

module frame_joiner #(
    parameter int PORT_COUNT = 4,
    parameter int TAG_WIDTH  = 16
) (
    input  logic                  clk,
    input  logic                  rst,

    input  join_pkg::join_beat_t  src_beat [PORT_COUNT],
    input  logic [PORT_COUNT-1:0] src_valid,
    output logic [PORT_COUNT-1:0] src_ready,

    output join_pkg::join_beat_t  dst_beat,
    output logic                  dst_valid,
    input  logic                  dst_ready,

    input  logic [TAG_WIDTH-1:0]  tag,
    output logic                  busy
);

    localparam int BEAT_BITS = 8 * join_pkg::BEAT_BYTES;
    localparam int TAG_BYTES = (TAG_WIDTH + BEAT_BITS - 1) / BEAT_BITS;
    localparam int PTR_W     = (TAG_BYTES > 1) ? $clog2(TAG_BYTES) : 1;
    localparam int SEL_W     = (PORT_COUNT > 1) ? $clog2(PORT_COUNT) : 1;

    join_pkg::join_state_t state;
    join_pkg::join_state_t state_next;

    logic [PTR_W-1:0] tag_ptr;
    logic [PTR_W-1:0] tag_ptr_next;
    logic [SEL_W-1:0] port_sel;
    logic [SEL_W-1:0] port_sel_next;
    logic             user_acc;
    logic             user_acc_next;

    // tag zero padded to whole bytes
    logic [TAG_BYTES*BEAT_BITS-1:0] tag_ext;

    join_pkg::join_beat_t sel_beat;
    logic                 sel_valid;
    logic                 last_port;
    logic                 tag_done;

    assign tag_ext   = (TAG_BYTES*BEAT_BITS)'(tag);
    assign sel_beat  = src_beat[port_sel];
    assign sel_valid = src_valid[port_sel];
    assign last_port = (port_sel == SEL_W'(PORT_COUNT - 1));
    assign tag_done  = (tag_ptr == PTR_W'(TAG_BYTES - 1));

    always_comb begin
        state_next    = state;
        tag_ptr_next  = tag_ptr;
        port_sel_next = port_sel;
        user_acc_next = user_acc;

        src_ready = '0;
        dst_valid = 1'b0;

        // tag byte by default, least significant first
        dst_beat.data = tag_ext[tag_ptr*BEAT_BITS +: BEAT_BITS];
        dst_beat.last = 1'b0;
        dst_beat.user = 1'b0;

        case (state)
            join_pkg::st_idle: begin
                tag_ptr_next  = '0;
                port_sel_next = '0;
                user_acc_next = 1'b0;
                // first tag byte goes out as soon as port 0 has data
                dst_valid = src_valid[0];
                if (src_valid[0] && dst_ready) begin
                    if (tag_done) begin
                        state_next = join_pkg::st_transfer;
                    end else begin
                        tag_ptr_next = tag_ptr + 1'b1;
                        state_next   = join_pkg::st_tag;
                    end
                end
            end
            join_pkg::st_tag: begin
                dst_valid = 1'b1;
                if (dst_ready) begin
                    if (tag_done) begin
                        tag_ptr_next = '0;
                        state_next   = join_pkg::st_transfer;
                    end else begin
                        tag_ptr_next = tag_ptr + 1'b1;
                    end
                end
            end
            join_pkg::st_transfer: begin
                dst_valid     = sel_valid;
                dst_beat.data = sel_beat.data;
                src_ready[port_sel] = dst_ready;

                // last and user only on the final byte of the last port
                if (last_port && sel_beat.last) begin
                    dst_beat.last = 1'b1;
                    dst_beat.user = user_acc | sel_beat.user;
                end

                if (sel_valid && dst_ready && sel_beat.last) begin
                    user_acc_next = user_acc | sel_beat.user;
                    if (last_port) begin
                        state_next = join_pkg::st_idle;
                    end else begin
                        port_sel_next = port_sel + 1'b1;
                    end
                end
            end
            default: begin
                state_next = join_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= join_pkg::st_idle;
            tag_ptr  <= '0;
            port_sel <= '0;
            user_acc <= 1'b0;
            busy     <= 1'b0;
        end else begin
            state    <= state_next;
            tag_ptr  <= tag_ptr_next;
            port_sel <= port_sel_next;
            user_acc <= user_acc_next;
            busy     <= (state_next != join_pkg::st_idle);
        end
    end

endmodule

// File: design/port_fifo.sv
// per-port input FIFO
`timescale 1ns/1ps

module port_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,

    input  join_pkg::join_beat_t wr_beat,
    input  logic                 wr_valid,
    output logic                 wr_ready,

    output join_pkg::join_beat_t rd_beat,
    output logic                 rd_valid,
    input  logic                 rd_ready
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    join_pkg::join_beat_t mem [FIFO_DEPTH];

    // extra top bit tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic full;
    logic empty;
    logic wr_fire;
    logic load;

    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_ready = !full;
    assign wr_fire = wr_valid && !full;

    // refill the output register when it is empty or being drained
    assign load = !empty && (!rd_valid || rd_ready);

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rd_beat <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr   <= rd_ptr + 1'b1;
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                // head consumed and nothing left behind it
                rd_valid <= 1'b0;
            end
        end
    end

endmodule

// File: design/join_pkg.sv
// frame joiner shared types
package join_pkg;

    // data bytes carried by one stream beat
    localparam int BEAT_BYTES = 1;

    // one byte-wide stream beat
    typedef struct packed {
        logic [7:0] data;
        // end of frame
        logic       last;
        // error flag
        logic       user;
    } join_beat_t;

    // joiner FSM states
    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_tag      = 2'd1,
        st_transfer = 2'd2
    } join_state_t;

endpackage
